//--- design/gat_attn_pipe.sv
`timescale 1ns/100ps
`include "gat_config.svh"

module gat_attn_pipe (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  gat_pkg::wgt_mat_t                       wgt_i,
  input  gat_pkg::att_vec_t                       att_i,
  input  logic                                    gat_ready_i,
  input  gat_pkg::h_vec_t                         h_data_i,
  input  logic                                    h_empty_i,
  input  logic [$clog2(`GAT_COEF_FIFO_DEPTH+1)-1:0] coef_count_i,
  output logic                                    h_rd_o,
  output logic                                    res_vld_o,
  output gat_pkg::wh_vec_t                        res_wh_o,
  output gat_pkg::coef_t                          res_coef_o
);

  import gat_pkg::*;

  localparam int CNT_W = $clog2(`GAT_COEF_FIFO_DEPTH + 1);
  localparam int OCC_W = CNT_W + 1;

  logic [OCC_W-1:0] occupancy;
  logic             s1_vld;
  wh_vec_t          s1_wh;
  wh_vec_t          proj;
  coef_t            score;

  // Queued coefficients plus both stages in flight
  assign occupancy = OCC_W'(coef_count_i) + OCC_W'(s1_vld) + OCC_W'(res_vld_o);

  assign h_rd_o = gat_ready_i && !h_empty_i &&
                  (occupancy < OCC_W'(`GAT_COEF_FIFO_DEPTH));

  // Projection Wh = W * h
  always_comb begin
    for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
      proj.f[j] = '0;
      for (int i = 0; i < `GAT_FEAT_IN; i++) begin
        proj.f[j] = proj.f[j] + $signed(wgt_i[j][i]) * $signed(h_data_i.f[i]);
      end
    end
  end

  // Raw attention score a . Wh
  always_comb begin
    score = '0;
    for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
      score = score + $signed(att_i[j]) * $signed(s1_wh.f[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld    <= 1'b0;
      res_vld_o <= 1'b0;
    end else begin
      s1_vld    <= h_rd_o;
      res_vld_o <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (h_rd_o) begin
      s1_wh <= proj;
    end
    if (s1_vld) begin
      res_wh_o <= s1_wh;
      // LeakyReLU, negative side floors toward minus infinity
      if (score[`GAT_COEF_W-1]) begin
        res_coef_o <= score >>> `GAT_LRELU_SHIFT;
      end else begin
        res_coef_o <= score;
      end
    end
  end

endmodule

//--- design/gat_pkg.sv
`include "gat_config.svh"

package gat_pkg;

  // Single feature, weight or attention element
  typedef logic signed [`GAT_DATA_W-1:0] elem_t;

  typedef struct packed {
    elem_t [`GAT_FEAT_IN-1:0] f;
  } h_vec_t;

  // One element of the projected vector Wh
  typedef logic signed [`GAT_WH_W-1:0] wh_elem_t;

  typedef struct packed {
    wh_elem_t [`GAT_FEAT_OUT-1:0] f;
  } wh_vec_t;

  // Attention score after LeakyReLU
  typedef logic signed [`GAT_COEF_W-1:0] coef_t;

  // Indexed [output][input]
  typedef elem_t [`GAT_FEAT_OUT-1:0][`GAT_FEAT_IN-1:0] wgt_mat_t;

  typedef elem_t [`GAT_FEAT_OUT-1:0] att_vec_t;

endpackage

//--- design/gat_score_top.sv
`timescale 1ns/100ps
`include "gat_config.svh"

module gat_score_top (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              gat_layer_i,
  input  logic                              wgt_load_done_i,
  input  gat_pkg::elem_t                    wgt_bram_dout_i,
  input  logic                              h_vld_i,
  input  gat_pkg::h_vec_t                   h_data_i,
  input  logic                              coef_rd_i,
  output logic [$clog2(`GAT_WGT_DEPTH)-1:0] wgt_bram_addrb_o,
  output logic                              gat_ready_o,
  output logic                              h_full_o,
  output logic                              wh_bram_ena_o,
  output logic [`GAT_WH_ADDR_W-1:0]         wh_bram_addra_o,
  output gat_pkg::wh_vec_t                  wh_bram_din_o,
  output gat_pkg::coef_t                    coef_dout_o,
  output logic                              coef_empty_o
);

  import gat_pkg::*;

  wgt_mat_t                                  wgt;
  att_vec_t                                  att;
  h_vec_t                                    h_head;
  logic                                      h_empty;
  logic                                      h_rd;
  logic                                      res_vld;
  wh_vec_t                                   res_wh;
  coef_t                                     res_coef;
  logic [$clog2(`GAT_COEF_FIFO_DEPTH+1)-1:0] coef_count;

  wgt_loader u_wgt_loader (
    .clk              (clk),
    .rst_n            (rst_n),
    .gat_layer_i      (gat_layer_i),
    .wgt_load_done_i  (wgt_load_done_i),
    .wgt_bram_dout_i  (wgt_bram_dout_i),
    .wgt_bram_addrb_o (wgt_bram_addrb_o),
    .wgt_o            (wgt),
    .att_o            (att),
    .gat_ready_o      (gat_ready_o)
  );

  sync_fifo #(
    .payload_t (h_vec_t),
    .DEPTH     (`GAT_H_FIFO_DEPTH)
  ) u_h_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (h_vld_i),
    .din_i   (h_data_i),
    .rd_i    (h_rd),
    .dout_o  (h_head),
    .empty_o (h_empty),
    .full_o  (h_full_o),
    .count_o ()
  );

  gat_attn_pipe u_attn_pipe (
    .clk          (clk),
    .rst_n        (rst_n),
    .wgt_i        (wgt),
    .att_i        (att),
    .gat_ready_i  (gat_ready_o),
    .h_data_i     (h_head),
    .h_empty_i    (h_empty),
    .coef_count_i (coef_count),
    .h_rd_o       (h_rd),
    .res_vld_o    (res_vld),
    .res_wh_o     (res_wh),
    .res_coef_o   (res_coef)
  );

  result_writer u_result_writer (
    .clk             (clk),
    .rst_n           (rst_n),
    .res_vld_i       (res_vld),
    .res_wh_i        (res_wh),
    .res_coef_i      (res_coef),
    .coef_rd_i       (coef_rd_i),
    .wh_bram_ena_o   (wh_bram_ena_o),
    .wh_bram_addra_o (wh_bram_addra_o),
    .wh_bram_din_o   (wh_bram_din_o),
    .coef_dout_o     (coef_dout_o),
    .coef_empty_o    (coef_empty_o),
    .coef_count_o    (coef_count)
  );

endmodule

//--- design/result_writer.sv
`timescale 1ns/100ps
`include "gat_config.svh"

module result_writer (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      res_vld_i,
  input  gat_pkg::wh_vec_t                          res_wh_i,
  input  gat_pkg::coef_t                            res_coef_i,
  input  logic                                      coef_rd_i,
  output logic                                      wh_bram_ena_o,
  output logic [`GAT_WH_ADDR_W-1:0]                 wh_bram_addra_o,
  output gat_pkg::wh_vec_t                          wh_bram_din_o,
  output gat_pkg::coef_t                            coef_dout_o,
  output logic                                      coef_empty_o,
  output logic [$clog2(`GAT_COEF_FIFO_DEPTH+1)-1:0] coef_count_o
);

  import gat_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wh_bram_ena_o   <= 1'b0;
      wh_bram_addra_o <= '0;
    end else begin
      wh_bram_ena_o <= res_vld_i;
      // Advance once the current word is written, wraps at the top
      if (wh_bram_ena_o) begin
        wh_bram_addra_o <= wh_bram_addra_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (res_vld_i) begin
      wh_bram_din_o <= res_wh_i;
    end
  end

  sync_fifo #(
    .payload_t (coef_t),
    .DEPTH     (`GAT_COEF_FIFO_DEPTH)
  ) u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (res_vld_i),
    .din_i   (res_coef_i),
    .rd_i    (coef_rd_i),
    .dout_o  (coef_dout_o),
    .empty_o (coef_empty_o),
    .full_o  (),
    .count_o (coef_count_o)
  );

endmodule

//--- design/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_i,
  input  payload_t                   din_i,
  input  logic                       rd_i,
  output payload_t                   dout_o,
  output logic                       empty_o,
  output logic                       full_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             wr_en;
  logic             rd_en;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_en   = wr_i && !full_o;
  assign rd_en   = rd_i && !empty_o;
  assign empty_o = (count_o == '0);
  assign full_o  = (count_o == CNT_W'(DEPTH));

  // Head is visible before the pop
  assign dout_o = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (wr_en && !rd_en) begin
        count_o <= count_o + 1'b1;
      end else if (rd_en && !wr_en) begin
        count_o <= count_o - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din_i;
    end
  end

endmodule

//--- design/wgt_loader.sv
`timescale 1ns/100ps
`include "gat_config.svh"

module wgt_loader (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              gat_layer_i,
  input  logic                              wgt_load_done_i,
  input  gat_pkg::elem_t                    wgt_bram_dout_i,
  output logic [$clog2(`GAT_WGT_DEPTH)-1:0] wgt_bram_addrb_o,
  output gat_pkg::wgt_mat_t                 wgt_o,
  output gat_pkg::att_vec_t                 att_o,
  output logic                              gat_ready_o
);

  localparam int                ADDR_W    = $clog2(`GAT_WGT_DEPTH);
  localparam int                W_WORDS   = `GAT_FEAT_OUT * `GAT_FEAT_IN;
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`GAT_WGT_DEPTH - 1);

  logic              busy;
  logic              cap_vld;
  logic [ADDR_W-1:0] cap_idx;
  logic              start;

  // Load runs once per reset
  assign start = gat_layer_i && wgt_load_done_i && !(busy || cap_vld || gat_ready_o);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy             <= 1'b0;
      wgt_bram_addrb_o <= '0;
      cap_vld          <= 1'b0;
      cap_idx          <= '0;
      gat_ready_o      <= 1'b0;
    end else begin
      if (start) begin
        busy <= 1'b1;
      end else if (busy && wgt_bram_addrb_o == LAST_ADDR) begin
        busy <= 1'b0;
      end
      if (busy && wgt_bram_addrb_o != LAST_ADDR) begin
        wgt_bram_addrb_o <= wgt_bram_addrb_o + 1'b1;
      end
      // Memory data lags the address by one cycle
      cap_vld <= busy;
      cap_idx <= wgt_bram_addrb_o;
      if (cap_vld && cap_idx == LAST_ADDR) begin
        gat_ready_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cap_vld) begin
      if (cap_idx < ADDR_W'(W_WORDS)) begin
        wgt_o[cap_idx / `GAT_FEAT_IN][cap_idx % `GAT_FEAT_IN] <= wgt_bram_dout_i;
      end else begin
        att_o[cap_idx - ADDR_W'(W_WORDS)] <= wgt_bram_dout_i;
      end
    end
  end

endmodule

//--- include/gat_config.svh
`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// Feature dimensions per node
`define GAT_FEAT_IN          4
`define GAT_FEAT_OUT         4

// Features, weights and attention elements are signed
`define GAT_DATA_W           8
// Full product plus growth of a 4-term sum
`define GAT_WH_W             18
`define GAT_COEF_W           28

// LeakyReLU slope of 1/8 on negative scores
`define GAT_LRELU_SHIFT      3

// W in words 0..15 at j*4+i, attention vector in words 16..19
`define GAT_WGT_DEPTH        20

`define GAT_H_FIFO_DEPTH     8
`define GAT_COEF_FIFO_DEPTH  4

`define GAT_WH_ADDR_W        7

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GAT score testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module gat_score_tb -o gat_score_sim

./obj_dir/gat_score_sim +verilator+error+limit+100 | tee sim.log

if grep -qF '*** FAILED ***' sim.log || ! grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

//--- sim.f
+incdir+include
design/gat_pkg.sv
design/sync_fifo.sv
design/wgt_loader.sv
design/gat_attn_pipe.sv
design/result_writer.sv
design/gat_score_top.sv
tests/gat_score_chk.sv
tests/gat_score_tb.sv

//--- tests/gat_score_chk.sv
`timescale 1ns/100ps
`include "gat_config.svh"

module gat_score_chk (
  input logic                      clk,
  input logic                      rst_n,
  input logic                      gat_ready_o,
  input logic                      wh_bram_ena_o,
  input logic [`GAT_WH_ADDR_W-1:0] wh_bram_addra_o,
  input logic                      h_full_o,
  input logic                      coef_empty_o
);

  // Failure count, read by the testbench
  int fails = 0;

  ready_held: assert property (@(posedge clk) disable iff (!rst_n)
      gat_ready_o |=> gat_ready_o) else begin
    $error("gat_ready_o fell after rising");
    fails++;
  end

  no_early_write: assert property (@(posedge clk) disable iff (!rst_n)
      wh_bram_ena_o |-> gat_ready_o) else begin
    $error("Wh write before the weights were loaded");
    fails++;
  end

  addr_step: assert property (@(posedge clk) disable iff (!rst_n)
      wh_bram_ena_o |=> wh_bram_addra_o == $past(wh_bram_addra_o) + 1'b1) else begin
    $error("Wh address did not step by one after a write");
    fails++;
  end

  full_vs_empty: assert property (@(posedge clk) disable iff (!rst_n)
      !(h_full_o && coef_empty_o)) else begin
    $error("Feature FIFO full while coefficient FIFO empty");
    fails++;
  end

endmodule

bind gat_score_top gat_score_chk chk0 (.*);

//--- tests/gat_score_tb.sv
`timescale 1ns/100ps
`include "gat_config.svh"

module gat_score_tb;

  import gat_pkg::*;

  logic                              clk = 1'b0;
  logic                              rst_n = 1'b0;
  logic                              gat_layer_i = 1'b0;
  logic                              wgt_load_done_i = 1'b0;
  elem_t                             wgt_bram_dout_i = '0;
  logic                              h_vld_i = 1'b0;
  h_vec_t                            h_data_i = '0;
  logic                              coef_rd_i = 1'b0;
  logic [$clog2(`GAT_WGT_DEPTH)-1:0] wgt_bram_addrb_o;
  logic                              gat_ready_o;
  logic                              h_full_o;
  logic                              wh_bram_ena_o;
  logic [`GAT_WH_ADDR_W-1:0]         wh_bram_addra_o;
  wh_vec_t                           wh_bram_din_o;
  coef_t                             coef_dout_o;
  logic                              coef_empty_o;

  // Address the weight memory latched on the previous cycle
  logic [$clog2(`GAT_WGT_DEPTH)-1:0] wgt_addr_q = '0;

  elem_t       wmem [`GAT_WGT_DEPTH];
  int          q_wh [$];
  int          q_coef [$];
  int          checks = 0;
  int          errors = 0;
  int          n_wr = 0;
  int          n;
  bit          pop_en = 1'b1;
  logic [31:0] rng = 32'd78950;

  gat_score_top dut0 (.*);

  always #20 clk = ~clk;

  // Weight memory, data follows the address by one cycle
  always @(negedge clk) begin
    wgt_bram_dout_i <= wmem[wgt_addr_q];
    wgt_addr_q      <= wgt_bram_addrb_o;
  end

  function automatic elem_t next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return elem_t'($signed(rng[4:0]));
  endfunction

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
    end
  endtask

  function automatic bit cond_met(input int sel);
    case (sel)
      0: return gat_ready_o;
      1: return wh_bram_ena_o;
      2: return !h_full_o;
      default: return q_coef.size() == 0;
    endcase
  endfunction

  // Counts falling edges until the selected condition holds
  task automatic wait_until(input int sel, input int limit, input string what, output int cnt);
    cnt = 0;
    while (!cond_met(sel) && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (!cond_met(sel)) begin
      errors++;
      $display("Timed out after %0d cycles waiting for %s", limit, what);
    end
  endtask

  // Pushes one random node and queues its expected Wh and coefficient
  task automatic send_node();
    h_vec_t h;
    int     wh;
    int     score;
    wait_until(2, 200, "h_full_o to clear", n);
    score = 0;
    for (int i = 0; i < `GAT_FEAT_IN; i++)
      h.f[i] = next_rand();
    for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
      wh = 0;
      for (int i = 0; i < `GAT_FEAT_IN; i++)
        wh += wmem[j * `GAT_FEAT_IN + i] * h.f[i];
      q_wh.push_back(wh);
      score += wmem[`GAT_FEAT_OUT * `GAT_FEAT_IN + j] * wh;
    end
    // Slope 1/8 below zero, rounded down
    q_coef.push_back(score < 0 ? (score - 7) / 8 : score);
    h_data_i = h;
    h_vld_i  = 1'b1;
    @(negedge clk);
    h_vld_i  = 1'b0;
  endtask

  // Outputs are stable on the falling edge
  always @(negedge clk) begin
    int want;
    coef_rd_i = pop_en && !coef_empty_o;
    if (coef_rd_i) begin
      want = q_coef.pop_front();
      check(int'($signed(coef_dout_o)) == want,
            $sformatf("coefficient %0d, expected %0d", $signed(coef_dout_o), want));
    end
    if (wh_bram_ena_o) begin
      check(int'(wh_bram_addra_o) == n_wr % (1 << `GAT_WH_ADDR_W),
            $sformatf("Wh address %0d, expected %0d", wh_bram_addra_o, n_wr));
      n_wr++;
      for (int j = 0; j < `GAT_FEAT_OUT; j++) begin
        want = q_wh.pop_front();
        check(int'($signed(wh_bram_din_o.f[j])) == want,
              $sformatf("Wh[%0d] %0d, expected %0d", j, $signed(wh_bram_din_o.f[j]), want));
      end
    end
  end

  initial begin
    for (int a = 0; a < `GAT_WGT_DEPTH; a++)
      wmem[a] = next_rand();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check(!gat_ready_o && !wh_bram_ena_o && !h_full_o && coef_empty_o, "outputs after reset");

    // Load-done alone must not start the load
    wgt_load_done_i = 1'b1;
    repeat (30) begin
      @(negedge clk);
      check(!gat_ready_o, "gat_ready_o rose with gat_layer_i low");
    end
    gat_layer_i = 1'b1;
    wait_until(0, 100, "gat_ready_o", n);
    // First sampling edge comes half a cycle after the drive
    check(n - 1 == 21, $sformatf("gat_ready_o after %0d cycles, expected 21", n - 1));

    // Single node through idle FIFOs
    send_node();
    // Counted from the edge that samples h_vld_i
    wait_until(1, 20, "the first Wh write", n);
    check(n == 3, $sformatf("Wh write %0d cycles after h_vld_i, expected 3", n));
    check(wh_bram_addra_o == '0, "first Wh write not at address 0");

    repeat (40)
      send_node();
    wait_until(3, 200, "the coefficient stream to drain", n);

    // Host stalls so the coefficient FIFO fills
    pop_en <= 1'b0;
    repeat (10)
      send_node();
    repeat (10) @(negedge clk);
    check(!coef_empty_o, "coefficient FIFO empty while the host is stalled");
    pop_en <= 1'b1;
    wait_until(3, 300, "coefficients to drain after the stall", n);
    check(q_wh.size() == 0, $sformatf("%0d Wh values never written", q_wh.size()));

    $display("Checks %0d, errors %0d, assertion failures %0d",
             checks, errors, dut0.chk0.fails);
    if (errors == 0 && dut0.chk0.fails == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
